//--- Bender.yml
package:
  name: cpu_core

sources:
  - rtl/cpuPkg.sv
  - rtl/decodeStage.sv
  - rtl/regFile.sv
  - rtl/execStage.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/tbCpuTop.sv

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Reset held over four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

//--- dv/tbCpuTop.sv
`timescale 1ns/1ps

module tbCpuTop import cpuPkg::*; ();

	localparam int clkPeriod = 40;
	// Reset, ALU, forwarding, $0 and random tests incl. drains
	localparam int numInstr = 8 + 14 + 12 + 9 + 203;

	logic     clk;
	logic     rst;
	logic     instrValid;
	instr_t   instr;
	logic     wbValid;
	regAddr_t wbAddr;
	word_t    wbData;

	// Reference model state
	word_t       refRegs [0:31];
	wbReq_t      pending [$];
	logic [31:0] lfsrState;
	string       curTest;

	tbClock i_tbClock (
		.clk (clk),
		.rst (rst)
	);

	cpuTop i_cpuTop (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbAddr     (wbAddr),
		.wbData     (wbData)
	);

	// ========================================
	// Helpers
	// ========================================

	function automatic instr_t rType(input logic [5:0] fn, input regAddr_t rd,
		input regAddr_t rs, input regAddr_t rt, input shamt_t sa);
		return {opSpecial, rs, rt, rd, sa, fn};
	endfunction

	function automatic instr_t iType(input logic [5:0] op, input regAddr_t rt,
		input regAddr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Galois step giving one output bit
	function automatic logic lfsrBit();
		logic out;
		out = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (out) begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsrBit()};
		end
		return val;
	endfunction

	// Registers 1 to 7 only
	function automatic regAddr_t randReg();
		regAddr_t r;
		r = regAddr_t'(randBits(3));
		if (r == '0) begin
			r = 5'd7;
		end
		return r;
	endfunction

	// Sequential ISA semantics without pipelining
	function automatic wbReq_t predict(input instr_t ins);
		wbReq_t      res;
		word_t       a;
		word_t       b;
		logic [15:0] imm;
		a = refRegs[ins[25:21]];
		b = refRegs[ins[20:16]];
		imm = ins[15:0];
		res.valid = 1'b1;
		res.addr = ins[15:11];
		res.data = '0;
		if (ins[31:26] == opSpecial) begin
			case (ins[5:0])
				fnAddu: res.data = a + b;
				fnSubu: res.data = a - b;
				fnAnd:  res.data = a & b;
				fnOr:   res.data = a | b;
				fnSlt:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fnSll:  res.data = b << ins[10:6];
				default: res.valid = 1'b0;
			endcase
		end else begin
			// Immediate group writes rt
			res.addr = ins[20:16];
			case (ins[31:26])
				opAddiu: res.data = a + {{16{imm[15]}}, imm};
				opOri:   res.data = a | {16'd0, imm};
				opLui:   res.data = {imm, 16'd0};
				default: res.valid = 1'b0;
			endcase
		end
		// $0 is never written
		res.valid = res.valid && (res.addr != '0);
		return res;
	endfunction

	task automatic checkEq(input string what, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Error: test %s, %s expected %h actual %h", curTest, what, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic compareWb(input wbReq_t exp);
		checkEq("wbValid", word_t'(exp.valid), word_t'(wbValid));
		if (exp.valid) begin
			checkEq("wbAddr", word_t'(exp.addr), word_t'(wbAddr));
			checkEq("wbData", exp.data, wbData);
		end
	endtask

	// Checks the op from three calls back and drives a new one
	task automatic issue(input logic valid, input instr_t ins);
		wbReq_t exp;
		@(posedge clk);
		#2;
		if (pending.size() == 3) begin
			compareWb(pending.pop_front());
		end
		instrValid = valid;
		instr = ins;
		exp = predict(ins);
		exp.valid = exp.valid && valid;
		if (exp.valid) begin
			refRegs[exp.addr] = exp.data;
		end
		pending.push_back(exp);
	endtask

	task automatic drain();
		repeat (3) issue(1'b0, '0);
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic resetQuiet();
		curTest = "reset";
		// Four reset cycles then four idle
		repeat (8) begin
			@(posedge clk);
			#2;
			checkEq("wbValid", '0, word_t'(wbValid));
		end
	endtask

	task automatic aluOps();
		curTest = "alu ops";
		issue(1'b1, iType(opLui, 1, 0, 16'h8000));
		issue(1'b1, iType(opOri, 1, 1, 16'h1234));
		// Negative immediate gets sign extended
		issue(1'b1, iType(opAddiu, 2, 0, 16'hfffb));
		// High bit set but zero extended
		issue(1'b1, iType(opOri, 3, 0, 16'hf00f));
		issue(1'b1, rType(fnAddu, 4, 2, 3, 0));
		issue(1'b1, rType(fnSubu, 5, 3, 2, 0));
		issue(1'b1, rType(fnAnd, 6, 1, 3, 0));
		issue(1'b1, rType(fnOr, 7, 2, 3, 0));
		// Negative against positive
		issue(1'b1, rType(fnSlt, 4, 2, 3, 0));
		issue(1'b1, rType(fnSlt, 5, 3, 2, 0));
		issue(1'b1, rType(fnSll, 6, 0, 3, 4));
		drain();
	endtask

	task automatic forwardPaths();
		curTest = "forwarding";
		issue(1'b1, iType(opAddiu, 1, 0, 16'd100));
		// Distance 1 from execute
		issue(1'b1, rType(fnAddu, 2, 1, 1, 0));
		issue(1'b0, '0);
		// Distance 2 from writeback
		issue(1'b1, iType(opAddiu, 3, 2, 16'd5));
		issue(1'b0, '0);
		issue(1'b0, '0);
		// Distance 3 through the register file
		issue(1'b1, rType(fnSubu, 4, 3, 1, 0));
		issue(1'b1, iType(opAddiu, 5, 4, 16'd1));
		// Both forward sources at once
		issue(1'b1, rType(fnOr, 6, 5, 4, 0));
		drain();
	endtask

	task automatic zeroAndUnknown();
		curTest = "reg0 and unknown";
		issue(1'b1, iType(opAddiu, 0, 0, 16'h0055));
		issue(1'b1, rType(fnOr, 1, 0, 0, 0));
		// Load opcode is not kept
		issue(1'b1, iType(6'b100011, 2, 1, 16'h0004));
		// Unknown funct
		issue(1'b1, rType(6'b011000, 3, 1, 2, 0));
		issue(1'b1, rType(fnOr, 4, 2, 0, 0));
		issue(1'b1, rType(fnOr, 5, 3, 0, 0));
		drain();
	endtask

	task automatic randomStream();
		instr_t   ins;
		int       sel;
		regAddr_t rd;
		regAddr_t rs;
		regAddr_t rt;
		curTest = "random";
		for (int n = 0; n < 200; n++) begin
			sel = randBits(4) % 9;
			rd = randReg();
			rs = randReg();
			rt = randReg();
			case (sel)
				0: ins = rType(fnAddu, rd, rs, rt, 0);
				1: ins = rType(fnSubu, rd, rs, rt, 0);
				2: ins = rType(fnAnd, rd, rs, rt, 0);
				3: ins = rType(fnOr, rd, rs, rt, 0);
				4: ins = rType(fnSlt, rd, rs, rt, 0);
				5: ins = rType(fnSll, rd, 0, rt, shamt_t'(randBits(5)));
				6: ins = iType(opAddiu, rd, rs, 16'(randBits(16)));
				7: ins = iType(opOri, rd, rs, 16'(randBits(16)));
				default: ins = iType(opLui, rd, 0, 16'(randBits(16)));
			endcase
			issue(1'b1, ins);
		end
		drain();
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================

	initial begin
		instrValid = 1'b0;
		instr = '0;
		lfsrState = 32'hbb30_d866;
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		resetQuiet();
		aluOps();
		forwardPaths();
		zeroAndUnknown();
		randomStream();
		$display("Test completed successfully");
		$finish;
	end

	// All cycles plus fifty spare
	initial begin
		#((numInstr + 50) * clkPeriod);
		$display("Timeout: the tests did not finish in time");
		$display("Test failed");
		$fatal(1);
	end

endmodule

//--- rtl/cpuPkg.sv
package cpuPkg;

	// ========================================
	// Basic widths
	// ========================================

	// One data word
	typedef logic [31:0] word_t;

	// Register number
	typedef logic [4:0] regAddr_t;

	// Raw instruction word
	typedef logic [31:0] instr_t;

	// Shift amount field of R-type
	typedef logic [4:0] shamt_t;

	// ========================================
	// Instruction encodings
	// ========================================

	// Opcode field values
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opAddiu   = 6'b001001;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opLui     = 6'b001111;

	// Funct field values under opSpecial
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSll  = 6'b000000;

	// ALU operation select
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluLui
	} aluOp_t;

	// ========================================
	// Stage payloads
	// ========================================

	// Decoded op handed from decode to execute
	typedef struct packed {
		logic     valid;
		aluOp_t   aluOp;
		word_t    opA;
		word_t    opB;
		regAddr_t dest;
	} decodedOp_t;

	// One register write, also used as forwarding source
	typedef struct packed {
		logic     valid;
		regAddr_t addr;
		word_t    data;
	} wbReq_t;

endpackage

//--- rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     instrValid,
	input  instr_t   instr,
	output logic     wbValid,
	output regAddr_t wbAddr,
	output word_t    wbData
);

	// Register file read side
	regAddr_t rsAddr;
	regAddr_t rtAddr;
	word_t    rsData;
	word_t    rtData;

	// Stage payloads
	decodedOp_t exOp;
	wbReq_t     exFwd;
	wbReq_t     wb;

	// ========================================
	// Stages
	// ========================================

	decodeStage i_decodeStage (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.rsAddr     (rsAddr),
		.rtAddr     (rtAddr),
		.rsData     (rsData),
		.rtData     (rtData),
		.exFwd      (exFwd),
		.wb         (wb),
		.exOp       (exOp)
	);

	regFile i_regFile (
		.clk    (clk),
		.rst    (rst),
		.rsAddr (rsAddr),
		.rtAddr (rtAddr),
		.rsData (rsData),
		.rtData (rtData),
		.wb     (wb)
	);

	execStage i_execStage (
		.clk   (clk),
		.rst   (rst),
		.exOp  (exOp),
		.exFwd (exFwd),
		.wb    (wb)
	);

	// Write report at the ports
	assign wbValid = wb.valid;
	assign wbAddr  = wb.addr;
	assign wbData  = wb.data;

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       instrValid,
	input  instr_t     instr,
	output regAddr_t   rsAddr,
	output regAddr_t   rtAddr,
	input  word_t      rsData,
	input  word_t      rtData,
	input  wbReq_t     exFwd,
	input  wbReq_t     wb,
	output decodedOp_t exOp
);

	// Decode register
	logic   decValid;
	instr_t decInstr;

	// Field split
	logic [5:0]  opcode;
	logic [5:0]  funct;
	regAddr_t    rsField;
	regAddr_t    rtField;
	regAddr_t    rdField;
	shamt_t      shamtField;
	logic [15:0] imm;

	// Decoder results
	logic     known;
	logic     useImm;
	logic     useShamt;
	aluOp_t   aluOp;
	regAddr_t dest;
	word_t    immExt;

	// Operands after forwarding
	word_t      rsFwd;
	word_t      rtFwd;
	decodedOp_t decOp;

	// Newest producer wins, register file last
	function automatic word_t fwdSelect(input regAddr_t src, input word_t rfData,
		input wbReq_t exSrc, input wbReq_t wbSrc);
		word_t val;
		val = rfData;
		if (exSrc.valid && exSrc.addr == src) begin
			val = exSrc.data;
		end else if (wbSrc.valid && wbSrc.addr == src) begin
			val = wbSrc.data;
		end
		return val;
	endfunction

	// ========================================
	// Decode register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
		end else begin
			decValid <= instrValid;
		end
		decInstr <= instr;
	end

	assign opcode     = decInstr[31:26];
	assign rsField    = decInstr[25:21];
	assign rtField    = decInstr[20:16];
	assign rdField    = decInstr[15:11];
	assign shamtField = decInstr[10:6];
	assign funct      = decInstr[5:0];
	assign imm        = decInstr[15:0];

	// Read ports straight from the fields
	assign rsAddr = rsField;
	assign rtAddr = rtField;

	// ========================================
	// Decoder and immediate extension
	// ========================================

	always_comb begin
		known    = 1'b1;
		useImm   = 1'b0;
		useShamt = 1'b0;
		aluOp    = aluAdd;
		dest     = rdField;
		immExt   = '0;
		case (opcode)
			opSpecial: begin
				// R-type writes rd
				case (funct)
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnSlt:  aluOp = aluSlt;
					fnSll: begin
						aluOp    = aluSll;
						useShamt = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			opAddiu: begin
				aluOp  = aluAdd;
				useImm = 1'b1;
				dest   = rtField;
				// Sign extended
				immExt = {{16{imm[15]}}, imm};
			end
			opOri: begin
				aluOp  = aluOr;
				useImm = 1'b1;
				dest   = rtField;
				immExt = {16'd0, imm};
			end
			opLui: begin
				// ALU moves it to the upper half
				aluOp  = aluLui;
				useImm = 1'b1;
				dest   = rtField;
				immExt = {16'd0, imm};
			end
			default: known = 1'b0;
		endcase
	end

	// Source 0 never matches a forward, regFile returns zero
	assign rsFwd = fwdSelect(rsField, rsData, exFwd, wb);
	assign rtFwd = fwdSelect(rtField, rtData, exFwd, wb);

	// Unknown op or write to $0 becomes a bubble
	assign decOp.valid = decValid && known && (dest != '0);
	assign decOp.aluOp = aluOp;
	assign decOp.opA   = useShamt ? {27'd0, shamtField} : rsFwd;
	assign decOp.opB   = useImm ? immExt : rtFwd;
	assign decOp.dest  = dest;

	// ========================================
	// Decode to execute register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			exOp.valid <= 1'b0;
		end else begin
			exOp.valid <= decOp.valid;
		end
		exOp.aluOp <= decOp.aluOp;
		exOp.opA   <= decOp.opA;
		exOp.opB   <= decOp.opB;
		exOp.dest  <= decOp.dest;
	end

	// No live op ever targets $0
	assert property (@(posedge clk) disable iff (rst) exOp.valid |-> exOp.dest != '0);

endmodule

//--- rtl/execStage.sv
`timescale 1ns/1ps

module execStage import cpuPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  decodedOp_t exOp,
	output wbReq_t     exFwd,
	output wbReq_t     wb
);

	// Shift count from low bits of opA
	shamt_t shiftAmt;

	// ALU output
	word_t aluResult;

	assign shiftAmt = exOp.opA[4:0];

	// ========================================
	// ALU
	// ========================================

	always_comb begin
		case (exOp.aluOp)
			// Wrapping, no overflow trap
			aluAdd: aluResult = exOp.opA + exOp.opB;
			aluSub: aluResult = exOp.opA - exOp.opB;
			aluAnd: aluResult = exOp.opA & exOp.opB;
			aluOr:  aluResult = exOp.opA | exOp.opB;
			aluSlt: begin
				// Signed compare
				if ($signed(exOp.opA) < $signed(exOp.opB)) begin
					aluResult = 32'd1;
				end else begin
					aluResult = 32'd0;
				end
			end
			aluSll: aluResult = exOp.opB << shiftAmt;
			// Immediate into upper half
			aluLui: aluResult = {exOp.opB[15:0], 16'd0};
			default: aluResult = '0;
		endcase
	end

	// ========================================
	// Forward and writeback
	// ========================================

	// Same-cycle result for the decode operand mux
	assign exFwd.valid = exOp.valid;
	assign exFwd.addr  = exOp.dest;
	assign exFwd.data  = aluResult;

	// Writeback register feeds regFile, decode and ports
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= exFwd.valid;
		end
		wb.addr <= exFwd.addr;
		wb.data <= exFwd.data;
	end

	// Decoder only issues known ALU ops
	assert property (@(posedge clk) disable iff (rst)
		exOp.valid |-> exOp.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui});

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  regAddr_t rsAddr,
	input  regAddr_t rtAddr,
	output word_t    rsData,
	output word_t    rtData,
	input  wbReq_t   wb
);

	// Architectural registers
	word_t regs [0:31];

	// ========================================
	// Write port
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// ========================================
	// Read ports
	// ========================================

	// Combinational read, $0 hardwired
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

	// Decoder drops $0 writes upstream
	assert property (@(posedge clk) disable iff (rst) wb.valid |-> wb.addr != '0);

endmodule

//--- src.f
rtl/cpuPkg.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/execStage.sv
rtl/cpuTop.sv
dv/tbClock.sv
dv/tbCpuTop.sv
